/* logic/ifu_params.svh */
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// fetch group geometry
`define IFU_SLOTS 4              // halfword slots per fetch group
`define IFU_GROUP_BYTES 8        // bytes per fetch group
`define IFU_SLOT_BITS 16         // data bits per halfword slot

// branch target buffer, one bank per slot
`define IFU_BTB_DEPTH 16         // entries per bank, index is addr[6:3]
`define IFU_BTB_TAG_BITS 4       // tag is addr[10:7]

`endif

/* logic/ifu_fetch_pkg.sv */
package ifu_fetch_pkg;

   // fetch controller state
   typedef enum logic {
      FETCH_IDLE = 1'b0,         // no fetching, waits for a redirecting flush
      FETCH_RUN  = 1'b1          // one request per cycle unless stalled
   } fetch_state_e;

   // halfword address, bit 0 is always zero and is dropped
   typedef logic [31:1] hw_addr_t;

endpackage

/* logic/ifu_bp_pkg.sv */
`include "ifu_params.svh"

package ifu_bp_pkg;

   // update command from execute
   typedef enum logic [1:0] {
      BTB_NOP   = 2'd0,          // no change
      BTB_WRITE = 2'd1,          // set valid, store tag and target
      BTB_CLEAR = 2'd2           // drop the valid bit
   } btb_op_e;

   typedef logic [$clog2(`IFU_BTB_DEPTH)-1:0] btb_index_t;   // entry index in a bank
   typedef logic [`IFU_BTB_TAG_BITS-1:0]      btb_tag_t;     // upper address tag

endpackage

/* logic/ifu_ifc_ctl.sv */
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_ifc_ctl (
   input  logic                    clk,
   input  logic                    reset,

   input  logic                    exu_flush_final,          // flush, redirect next cycle
   input  logic                    dec_tlu_flush_noredir_wb, // flush that stops fetching
   input  ifu_fetch_pkg::hw_addr_t exu_flush_path_final,     // flush target
   input  logic                    dec_ib_full,              // decode buffer back-pressure

   input  logic                    pred_taken_f1,            // a slot of this group is taken
   input  ifu_fetch_pkg::hw_addr_t pred_target_f1,           // its predicted target

   output ifu_fetch_pkg::hw_addr_t fetch_addr_f1,            // current F1 address
   output logic                    fetch_req_f1,             // request issued this cycle
   output logic                    ic_rd_en,                 // memory read strobe
   output logic [31:3]             ic_rw_addr                // group address to memory
);

   ifu_fetch_pkg::fetch_state_e fetch_state;   // idle or running
   ifu_fetch_pkg::hw_addr_t     group_base;    // F1 address with slot bits cleared
   ifu_fetch_pkg::hw_addr_t     seq_addr;      // base of the following group
   ifu_fetch_pkg::hw_addr_t     next_addr;     // address after a request

   //*******************************************************************
   // next address choice
   //*******************************************************************

   assign group_base = {fetch_addr_f1[31:3], 2'b00};   // drop start slot
   assign seq_addr   = group_base + ifu_fetch_pkg::hw_addr_t'(`IFU_GROUP_BYTES / 2);
   assign next_addr  = pred_taken_f1 ? pred_target_f1 : seq_addr;   // btb wins over seq

   // no request while idle, stalled or in the flush cycle
   assign fetch_req_f1 = (fetch_state == ifu_fetch_pkg::FETCH_RUN) &
                         ~dec_ib_full & ~exu_flush_final;

   assign ic_rd_en   = fetch_req_f1;             // memory answers one cycle later
   assign ic_rw_addr = fetch_addr_f1[31:3];      // whole group is read

   //*******************************************************************
   // state and F1 address
   //*******************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         fetch_state   <= ifu_fetch_pkg::FETCH_IDLE;   // wait for first redirect
         fetch_addr_f1 <= '0;
      end else if (exu_flush_final) begin
         fetch_addr_f1 <= exu_flush_path_final;        // flush has priority over prediction
         if (dec_tlu_flush_noredir_wb) begin
            fetch_state <= ifu_fetch_pkg::FETCH_IDLE;  // halt fetching
         end else begin
            fetch_state <= ifu_fetch_pkg::FETCH_RUN;
         end
      end else if (fetch_req_f1) begin
         fetch_addr_f1 <= next_addr;                   // advance only on a request
      end
   end

endmodule

/* logic/ifu_btb_bank.sv */
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_btb_bank #(
   parameter int bank_id = 0                                  // slot number of this bank
) (
   input  logic                    clk,
   input  logic                    reset,

   input  ifu_fetch_pkg::hw_addr_t fetch_addr_f1,             // lookup address
   input  ifu_bp_pkg::btb_op_e     btb_update_op,             // write or clear from execute
   input  ifu_fetch_pkg::hw_addr_t btb_update_pc,             // branch pc being updated
   input  ifu_fetch_pkg::hw_addr_t btb_update_target,         // branch target to store

   output logic                    hit,                       // valid tag match at or after start
   output ifu_fetch_pkg::hw_addr_t target                     // stored target of the entry
);

   logic [`IFU_BTB_DEPTH-1:0] entry_valid;                        // per entry valid
   ifu_bp_pkg::btb_tag_t      entry_tag    [`IFU_BTB_DEPTH];      // per entry tag
   ifu_fetch_pkg::hw_addr_t   entry_target [`IFU_BTB_DEPTH];      // per entry target

   ifu_bp_pkg::btb_index_t    rd_index;
   ifu_bp_pkg::btb_tag_t      rd_tag;
   ifu_bp_pkg::btb_index_t    wr_index;
   logic                      wr_own;      // update pc selects this bank
   logic                      slot_live;   // bank slot not before start slot

   //*******************************************************************
   // lookup
   //*******************************************************************

   assign rd_index  = fetch_addr_f1[6:3];
   assign rd_tag    = fetch_addr_f1[10:7];
   assign slot_live = bank_id >= int'(fetch_addr_f1[2:1]);   // earlier slots never hit

   assign hit    = entry_valid[rd_index] & (entry_tag[rd_index] == rd_tag) & slot_live;
   assign target = entry_target[rd_index];

   //*******************************************************************
   // update
   //*******************************************************************

   assign wr_index = btb_update_pc[6:3];
   assign wr_own   = btb_update_pc[2:1] == 2'(bank_id);

   always_ff @(posedge clk) begin
      if (reset) begin
         entry_valid <= '0;                                   // empty btb
      end else if (wr_own && btb_update_op == ifu_bp_pkg::BTB_WRITE) begin
         entry_valid[wr_index] <= 1'b1;
      end else if (wr_own && btb_update_op == ifu_bp_pkg::BTB_CLEAR) begin
         entry_valid[wr_index] <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (wr_own && btb_update_op == ifu_bp_pkg::BTB_WRITE) begin
         entry_tag[wr_index]    <= btb_update_pc[10:7];       // new content seen next cycle
         entry_target[wr_index] <= btb_update_target;
      end
   end

endmodule

/* logic/ifu_bp_sel.sv */
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_bp_sel (
   input  logic                                       clk,
   input  logic                                       reset,

   input  ifu_fetch_pkg::hw_addr_t                    fetch_addr_f1,       // F1 address
   input  logic                                       fetch_req_f1,        // request this cycle
   input  logic [`IFU_SLOTS-1:0]                      bank_hit,            // hit per slot
   input  ifu_fetch_pkg::hw_addr_t [`IFU_SLOTS-1:0]   bank_target,         // target per slot
   input  logic                                       dec_tlu_bpred_disable,
   input  logic [`IFU_SLOTS*`IFU_SLOT_BITS-1:0]       ic_rd_data,          // F2 memory data

   output logic                                       pred_taken_f1,       // redirect next fetch
   output ifu_fetch_pkg::hw_addr_t                    pred_target_f1,

   output logic                                       ifu_fetch_valid,     // F2 group valid
   output logic [`IFU_SLOTS-1:0]                      ifu_fetch_val,       // F2 slot mask
   output ifu_fetch_pkg::hw_addr_t                    ifu_fetch_pc,        // F2 fetch address
   output logic [`IFU_SLOTS*`IFU_SLOT_BITS-1:0]       ifu_fetch_data,      // F2 group data
   output logic                                       ifu_bp_taken,        // F2 group has taken slot
   output ifu_fetch_pkg::hw_addr_t                    ifu_bp_target        // F2 predicted target
);

   logic [`IFU_SLOTS-1:0] hit_eff;      // hits after global disable
   logic                  any_taken;
   logic [1:0]            taken_slot;   // lowest hitting slot
   logic [1:0]            start_slot;
   logic [1:0]            end_slot;     // last slot kept in the mask
   logic [`IFU_SLOTS-1:0] mask_f1;
   logic [`IFU_SLOTS-1:0] mask_f2;

   //*******************************************************************
   // F1 slot selection
   //*******************************************************************

   assign hit_eff    = bank_hit & {`IFU_SLOTS{~dec_tlu_bpred_disable}};
   assign start_slot = fetch_addr_f1[2:1];

   always_comb begin
      any_taken  = 1'b0;
      taken_slot = '0;
      for (int k = `IFU_SLOTS - 1; k >= 0; k--) begin   // downward scan, lowest wins
         if (hit_eff[k]) begin
            any_taken  = 1'b1;
            taken_slot = 2'(k);
         end
      end
   end

   assign end_slot = any_taken ? taken_slot : 2'(`IFU_SLOTS - 1);

   always_comb begin
      for (int k = 0; k < `IFU_SLOTS; k++) begin
         mask_f1[k] = (2'(k) >= start_slot) && (2'(k) <= end_slot);   // start..taken
      end
   end

   assign pred_taken_f1  = fetch_req_f1 & any_taken;      // only a real request redirects
   assign pred_target_f1 = bank_target[taken_slot];

   //*******************************************************************
   // F2 stage
   //*******************************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         ifu_fetch_valid <= 1'b0;
         ifu_bp_taken    <= 1'b0;
      end else begin
         ifu_fetch_valid <= fetch_req_f1;   // fixed one cycle latency
         ifu_bp_taken    <= pred_taken_f1;
      end
   end

   always_ff @(posedge clk) begin
      if (fetch_req_f1) begin
         mask_f2       <= mask_f1;
         ifu_fetch_pc  <= fetch_addr_f1;
         ifu_bp_target <= pred_target_f1;
      end
   end

   assign ifu_fetch_val  = ifu_fetch_valid ? mask_f2 : '0;   // no stale mask when idle
   assign ifu_fetch_data = ic_rd_data;                       // memory already answers in F2

endmodule

/* logic/ifu.sv */
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu (
   input  logic                                 clk,
   input  logic                                 reset,

   input  logic                                 exu_flush_final,            // flush with redirect
   input  logic                                 dec_tlu_flush_noredir_wb,   // flush, stop fetch
   input  ifu_fetch_pkg::hw_addr_t              exu_flush_path_final,       // flush address
   input  logic                                 dec_ib_full,                // decode buffer full
   input  logic                                 dec_tlu_bpred_disable,      // disable all prediction

   input  ifu_bp_pkg::btb_op_e                  btb_update_op,              // btb update command
   input  ifu_fetch_pkg::hw_addr_t              btb_update_pc,
   input  ifu_fetch_pkg::hw_addr_t              btb_update_target,

   output logic                                 ic_rd_en,                   // memory read
   output logic [31:3]                          ic_rw_addr,
   input  logic [`IFU_SLOTS*`IFU_SLOT_BITS-1:0] ic_rd_data,                 // one cycle later

   output logic                                 ifu_fetch_valid,
   output logic [`IFU_SLOTS-1:0]                ifu_fetch_val,
   output ifu_fetch_pkg::hw_addr_t              ifu_fetch_pc,
   output logic [`IFU_SLOTS*`IFU_SLOT_BITS-1:0] ifu_fetch_data,
   output logic                                 ifu_bp_taken,
   output ifu_fetch_pkg::hw_addr_t              ifu_bp_target
);

   ifu_fetch_pkg::hw_addr_t                  fetch_addr_f1;   // controller to banks and selector
   logic                                     fetch_req_f1;
   logic                                     pred_taken_f1;   // selector back to controller
   ifu_fetch_pkg::hw_addr_t                  pred_target_f1;
   logic [`IFU_SLOTS-1:0]                    bank_hit;        // one per slot bank
   ifu_fetch_pkg::hw_addr_t [`IFU_SLOTS-1:0] bank_target;

   //*******************************************************************
   // fetch control
   //*******************************************************************

   ifu_ifc_ctl ifc (.*);

   //*******************************************************************
   // btb banks, one per halfword slot
   //*******************************************************************

   for (genvar g = 0; g < `IFU_SLOTS; g++) begin : g_btb_bank
      ifu_btb_bank #(.bank_id(g)) btb_bank (
         .clk               (clk),
         .reset             (reset),
         .fetch_addr_f1     (fetch_addr_f1),
         .btb_update_op     (btb_update_op),      // each bank decodes its own writes
         .btb_update_pc     (btb_update_pc),
         .btb_update_target (btb_update_target),
         .hit               (bank_hit[g]),
         .target            (bank_target[g])
      );
   end

   // slot selection and F2 outputs
   ifu_bp_sel bp_sel (.*);

endmodule

/* tb/ifu_checker.sv */
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_checker (
   input  logic                                 clk,
   input  logic                                 reset,
   input  logic                                 exu_flush_final,
   input  logic                                 dec_tlu_flush_noredir_wb,
   input  ifu_fetch_pkg::hw_addr_t              exu_flush_path_final,
   input  logic                                 dec_ib_full,
   input  logic                                 dec_tlu_bpred_disable,
   input  ifu_bp_pkg::btb_op_e                  btb_update_op,
   input  ifu_fetch_pkg::hw_addr_t              btb_update_pc,
   input  ifu_fetch_pkg::hw_addr_t              btb_update_target,
   input  logic                                 ic_rd_en,
   input  logic [31:3]                          ic_rw_addr,
   input  logic                                 ifu_fetch_valid,
   input  logic [`IFU_SLOTS-1:0]                ifu_fetch_val,
   input  ifu_fetch_pkg::hw_addr_t              ifu_fetch_pc,
   input  logic [`IFU_SLOTS*`IFU_SLOT_BITS-1:0] ifu_fetch_data,
   input  logic                                 ifu_bp_taken,
   input  ifu_fetch_pkg::hw_addr_t              ifu_bp_target,
   output int                                   error_count,   // mismatches seen
   output int                                   check_count,   // compares made
   output int                                   taken_count    // predicted groups
);

   ifu_fetch_pkg::fetch_state_e state;      // model of the fetch FSM
   ifu_fetch_pkg::hw_addr_t     addr_f1;    // model F1 address
   logic                        f2_valid;   // expected F2 outputs for next cycle
   logic [`IFU_SLOTS-1:0]       f2_mask;
   ifu_fetch_pkg::hw_addr_t     f2_pc;
   logic                        f2_taken;
   ifu_fetch_pkg::hw_addr_t     f2_target;

   logic                    model_valid  [`IFU_SLOTS][`IFU_BTB_DEPTH];   // reference btb
   ifu_bp_pkg::btb_tag_t    model_tag    [`IFU_SLOTS][`IFU_BTB_DEPTH];
   ifu_fetch_pkg::hw_addr_t model_target [`IFU_SLOTS][`IFU_BTB_DEPTH];

   task automatic compare_value(input string sig, input logic [63:0] exp_v,
                                input logic [63:0] act_v);
      check_count++;
      if (act_v !== exp_v) begin
         error_count++;
         $display("** Error at %0d ns: %s expected %h, actual %h", $time, sig, exp_v, act_v);
      end
   endtask

   // slot k holds low 16 bits of its halfword address xor a5a5
   function automatic logic [63:0] group_data(input ifu_fetch_pkg::hw_addr_t pc);
      ifu_fetch_pkg::hw_addr_t hw;
      logic [63:0]             data;
      for (int k = 0; k < `IFU_SLOTS; k++) begin
         hw = {pc[31:3], 2'b00} + ifu_fetch_pkg::hw_addr_t'(k);
         data[16*k +: 16] = hw[16:1] ^ 16'hA5A5;
      end
      return data;
   endfunction

   //**********************************************************************
   // per cycle compare, then model step
   //**********************************************************************

   always @(posedge clk) begin : model_step
      logic                  exp_req;
      logic                  hit;
      int                    taken_k;
      int                    start;
      logic [`IFU_SLOTS-1:0] mask;
      if (reset) begin
         state       = ifu_fetch_pkg::FETCH_IDLE;
         addr_f1     = '0;
         f2_valid    = 1'b0;
         f2_taken    = 1'b0;
         error_count = 0;
         check_count = 0;
         taken_count = 0;
         for (int k = 0; k < `IFU_SLOTS; k++)
            for (int i = 0; i < `IFU_BTB_DEPTH; i++)
               model_valid[k][i] = 1'b0;                 // btb empty after reset
      end else begin
         compare_value("ifu_fetch_valid", 64'(f2_valid), 64'(ifu_fetch_valid));
         compare_value("ifu_bp_taken", 64'(f2_taken), 64'(ifu_bp_taken));
         compare_value("ifu_fetch_val", f2_valid ? 64'(f2_mask) : 64'd0, 64'(ifu_fetch_val));
         if (f2_valid) begin
            compare_value("ifu_fetch_pc", 64'(f2_pc), 64'(ifu_fetch_pc));
            compare_value("ifu_fetch_data", group_data(f2_pc), ifu_fetch_data);
         end
         if (f2_taken) compare_value("ifu_bp_target", 64'(f2_target), 64'(ifu_bp_target));

         exp_req = state == ifu_fetch_pkg::FETCH_RUN && !dec_ib_full && !exu_flush_final;
         compare_value("ic_rd_en", 64'(exp_req), 64'(ic_rd_en));
         if (exp_req) compare_value("ic_rw_addr", 64'(addr_f1[31:3]), 64'(ic_rw_addr));

         start   = int'(addr_f1[2:1]);                   // slots below never hit
         taken_k = -1;
         for (int k = 0; k < `IFU_SLOTS; k++) begin
            hit = model_valid[k][addr_f1[6:3]] && model_tag[k][addr_f1[6:3]] == addr_f1[10:7]
                  && k >= start && !dec_tlu_bpred_disable;
            if (hit && taken_k < 0) taken_k = k;         // first taken slot
         end
         for (int k = 0; k < `IFU_SLOTS; k++)
            mask[k] = k >= start && k <= (taken_k < 0 ? `IFU_SLOTS - 1 : taken_k);

         f2_valid = exp_req;
         f2_taken = exp_req && taken_k >= 0;
         if (exp_req) begin
            f2_mask = mask;
            f2_pc   = addr_f1;
         end
         if (f2_taken) begin
            f2_target = model_target[taken_k][addr_f1[6:3]];
            taken_count++;
         end

         if (exu_flush_final) begin
            addr_f1 = exu_flush_path_final;              // flush beats prediction
            state   = dec_tlu_flush_noredir_wb ? ifu_fetch_pkg::FETCH_IDLE
                                               : ifu_fetch_pkg::FETCH_RUN;
         end else if (exp_req) begin
            addr_f1 = f2_taken ? f2_target : {addr_f1[31:3], 2'b00} + 31'd4;   // next group
         end

         // updates land after the lookup of this cycle
         if (btb_update_op == ifu_bp_pkg::BTB_WRITE) begin
            model_valid[btb_update_pc[2:1]][btb_update_pc[6:3]]  = 1'b1;
            model_tag[btb_update_pc[2:1]][btb_update_pc[6:3]]    = btb_update_pc[10:7];
            model_target[btb_update_pc[2:1]][btb_update_pc[6:3]] = btb_update_target;
         end else if (btb_update_op == ifu_bp_pkg::BTB_CLEAR) begin
            model_valid[btb_update_pc[2:1]][btb_update_pc[6:3]]  = 1'b0;
         end
      end
   end

endmodule

/* tb/ifu_tb.sv */
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu_tb;

   localparam int NUM_CYCLES = 1500;                            // random stimulus cycles
   localparam int CLK_NS     = 8;
   localparam int TIMEOUT_NS = (NUM_CYCLES + 40) * CLK_NS + 500;   // run length plus margin

   logic                                 clk;
   logic                                 reset;
   logic                                 exu_flush_final;
   logic                                 dec_tlu_flush_noredir_wb;
   ifu_fetch_pkg::hw_addr_t              exu_flush_path_final;
   logic                                 dec_ib_full;
   logic                                 dec_tlu_bpred_disable;
   ifu_bp_pkg::btb_op_e                  btb_update_op;
   ifu_fetch_pkg::hw_addr_t              btb_update_pc;
   ifu_fetch_pkg::hw_addr_t              btb_update_target;
   logic                                 ic_rd_en;
   logic [31:3]                          ic_rw_addr;
   logic [`IFU_SLOTS*`IFU_SLOT_BITS-1:0] ic_rd_data = '0;
   logic                                 ifu_fetch_valid;
   logic [`IFU_SLOTS-1:0]                ifu_fetch_val;
   ifu_fetch_pkg::hw_addr_t              ifu_fetch_pc;
   logic [`IFU_SLOTS*`IFU_SLOT_BITS-1:0] ifu_fetch_data;
   logic                                 ifu_bp_taken;
   ifu_fetch_pkg::hw_addr_t              ifu_bp_target;
   int                                   error_count;
   int                                   check_count;
   int                                   taken_count;
   int                                   disable_left;   // cycles left in a disable period

   ifu DUT (.*);
   ifu_checker chk (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // instruction memory answers one cycle after the read
   always @(posedge clk) begin
      if (ic_rd_en) begin
         for (int k = 0; k < `IFU_SLOTS; k++)
            ic_rd_data[16*k +: 16] <= {ic_rw_addr[16:3], 2'(k)} ^ 16'hA5A5;   // low hw addr bits
      end
   end

   // halfword address in a 256 byte window that spans two tags
   function automatic ifu_fetch_pkg::hw_addr_t random_addr();
      logic [31:0] byte_addr;
      byte_addr = 32'h0000_1000 + ($urandom % 256);
      return byte_addr[31:1];
   endfunction

   task automatic drive_cycle();
      int pick;
      exu_flush_final          = ($urandom % 24) == 0;
      dec_tlu_flush_noredir_wb = exu_flush_final && ($urandom % 6) == 0;   // stop fetching
      exu_flush_path_final     = random_addr();
      dec_ib_full              = ($urandom % 5) == 0;
      if (disable_left > 0) disable_left--;
      else if (($urandom % 150) == 0) disable_left = 20 + ($urandom % 30);
      dec_tlu_bpred_disable = disable_left > 0;
      pick = $urandom % 8;
      if (pick < 2) btb_update_op = ifu_bp_pkg::BTB_WRITE;
      else if (pick == 2) btb_update_op = ifu_bp_pkg::BTB_CLEAR;
      else btb_update_op = ifu_bp_pkg::BTB_NOP;
      btb_update_pc     = random_addr();
      btb_update_target = random_addr();
   endtask

   //**********************************************************************
   // stimulus on the falling edge
   //**********************************************************************

   initial begin
      void'($urandom(1525));
      reset                    = 1'b1;
      exu_flush_final          = 1'b0;
      dec_tlu_flush_noredir_wb = 1'b0;
      exu_flush_path_final     = '0;
      dec_ib_full              = 1'b0;
      dec_tlu_bpred_disable    = 1'b0;
      btb_update_op            = ifu_bp_pkg::BTB_NOP;
      btb_update_pc            = '0;
      btb_update_target        = '0;
      disable_left             = 0;
      repeat (3) @(negedge clk);                   // three reset cycles
      reset                = 1'b0;
      exu_flush_final      = 1'b1;                  // first redirect starts fetching
      exu_flush_path_final = random_addr();
      @(negedge clk);
      repeat (NUM_CYCLES) begin
         drive_cycle();
         @(negedge clk);
      end
      exu_flush_final = 1'b0;
      dec_ib_full     = 1'b1;                       // quiet cycles let F2 drain
      btb_update_op   = ifu_bp_pkg::BTB_NOP;
      repeat (3) @(negedge clk);
      $display("checks %0d, predicted groups %0d, errors %0d",
               check_count, taken_count, error_count);
      if (taken_count == 0) $display("no predicted fetch group was seen during the run");
      if (error_count == 0 && taken_count > 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
      $display("tests failed");
      $finish;
   end

endmodule

/* src.f */
+incdir+logic
logic/ifu_fetch_pkg.sv
logic/ifu_bp_pkg.sv
logic/ifu_ifc_ctl.sv
logic/ifu_btb_bank.sv
logic/ifu_bp_sel.sv
logic/ifu.sv
tb/ifu_checker.sv
tb/ifu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the ifu testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module ifu_tb -f src.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vifu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "all tests passed" "$LOG"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail, see $LOG"
exit 1
